//--- vna_pkg.sv
package vna_pkg;

    typedef logic signed [15:0] sample_t;

    typedef struct packed {
        sample_t i;
        sample_t q;
    } iq_t;

    // One accepted beat, forward and reverse wave at each port
    typedef struct packed {
        iq_t fwd1;
        iq_t rev1;
        iq_t fwd2;
        iq_t rev2;
    } adc_beat_t;

    typedef logic [15:0] mag_t;

    // Full circle is 65536
    typedef logic [15:0] phase_t;

    typedef struct packed {
        mag_t   mag;
        phase_t phase;
    } polar_t;

    typedef struct packed {
        mag_t   mag_b;
        mag_t   mag_a;
        phase_t phase;
    } s_param_t;

    typedef struct packed {
        s_param_t s11;
        s_param_t s12;
        s_param_t s21;
        s_param_t s22;
    } s_matrix_t;

    typedef logic [3:0] avg_log2_t;

    localparam int FIR_TAPS  = 15;
    localparam int FIR_SHIFT = 15;

    // Symmetric low-pass, taps sum to 32768 for unity gain at DC
    localparam sample_t FIR_COEFFS [FIR_TAPS] = '{
        -16'sd120, -16'sd240, 16'sd0, 16'sd960, 16'sd2540, 16'sd4340, 16'sd5760, 16'sd6288,
        16'sd5760, 16'sd4340, 16'sd2540, 16'sd960, 16'sd0, -16'sd240, -16'sd120
    };

    typedef logic signed [35:0] fir_acc_t;

    localparam int CORDIC_STAGES = 12;

    // atan(2^-k) in phase_t units
    localparam phase_t CORDIC_ATAN [CORDIC_STAGES] = '{
        16'd8192, 16'd4836, 16'd2555, 16'd1297, 16'd651, 16'd326,
        16'd163, 16'd81, 16'd41, 16'd20, 16'd10, 16'd5
    };

    // Holds a rotated vector with the CORDIC gain of about 1.647
    typedef logic signed [18:0] cordic_t;

    localparam int AVG_LOG2_MAX = 10;

    typedef logic signed [26:0] avg_acc_t;

endpackage

//--- fir_15.sv
`timescale 1ns/1ns

module fir_15 (
    input  logic             aclk,
    input  logic             arst_n,
    input  logic             shift,
    input  vna_pkg::sample_t sample,
    output vna_pkg::sample_t filtered
);

    // The incoming sample is tap 0, the stored samples are taps 1 to 14
    vna_pkg::sample_t  hist [vna_pkg::FIR_TAPS-1];
    vna_pkg::fir_acc_t acc;
    vna_pkg::fir_acc_t scaled;

    always_comb begin
        acc = vna_pkg::fir_acc_t'(sample) * vna_pkg::fir_acc_t'(vna_pkg::FIR_COEFFS[0]);
        for (int j = 1; j < vna_pkg::FIR_TAPS; j++) begin
            acc = acc + vna_pkg::fir_acc_t'(hist[j-1])
                      * vna_pkg::fir_acc_t'(vna_pkg::FIR_COEFFS[j]);
        end
        scaled = acc >>> vna_pkg::FIR_SHIFT;
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int j = 0; j < vna_pkg::FIR_TAPS - 1; j++) begin
                hist[j] <= '0;
            end
            filtered <= '0;
        end else if (shift) begin
            hist[0] <= sample;
            for (int j = 1; j < vna_pkg::FIR_TAPS - 1; j++) begin
                hist[j] <= hist[j-1];
            end

            // Clip to the 16-bit range
            if (scaled > vna_pkg::fir_acc_t'(32767)) begin
                filtered <= 16'sh7fff;
            end else if (scaled < vna_pkg::fir_acc_t'(-32768)) begin
                filtered <= 16'sh8000;
            end else begin
                filtered <= vna_pkg::sample_t'(scaled);
            end
        end
    end

endmodule

//--- cordic_polar.sv
`timescale 1ns/1ns

module cordic_polar (
    input  logic            aclk,
    input  logic            arst_n,
    input  logic            advance,
    input  vna_pkg::iq_t    iq,
    output vna_pkg::polar_t polar
);

    // Stage 0 is the pre-rotation register, stage k+1 follows iteration k
    vna_pkg::cordic_t x_q [vna_pkg::CORDIC_STAGES+1];
    vna_pkg::cordic_t y_q [vna_pkg::CORDIC_STAGES+1];
    vna_pkg::phase_t  z_q [vna_pkg::CORDIC_STAGES+1];

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k <= vna_pkg::CORDIC_STAGES; k++) begin
                x_q[k] <= '0;
                y_q[k] <= '0;
                z_q[k] <= '0;
            end
        end else if (advance) begin
            // Left half plane is turned by 180 degrees first
            if (iq.i < 0) begin
                x_q[0] <= -vna_pkg::cordic_t'(iq.i);
                y_q[0] <= -vna_pkg::cordic_t'(iq.q);
                z_q[0] <= 16'h8000;
            end else begin
                x_q[0] <= vna_pkg::cordic_t'(iq.i);
                y_q[0] <= vna_pkg::cordic_t'(iq.q);
                z_q[0] <= '0;
            end

            // Each iteration rotates toward the positive i axis
            for (int k = 0; k < vna_pkg::CORDIC_STAGES; k++) begin
                if (y_q[k] >= 0) begin
                    x_q[k+1] <= x_q[k] + (y_q[k] >>> k);
                    y_q[k+1] <= y_q[k] - (x_q[k] >>> k);
                    z_q[k+1] <= z_q[k] + vna_pkg::CORDIC_ATAN[k];
                end else begin
                    x_q[k+1] <= x_q[k] - (y_q[k] >>> k);
                    y_q[k+1] <= y_q[k] + (x_q[k] >>> k);
                    z_q[k+1] <= z_q[k] - vna_pkg::CORDIC_ATAN[k];
                end
            end
        end
    end

    // Shift by 2 brings the gain-scaled length back under 16 bits
    assign polar.mag   = vna_pkg::mag_t'(x_q[vna_pkg::CORDIC_STAGES] >>> 2);
    assign polar.phase = z_q[vna_pkg::CORDIC_STAGES];

endmodule

//--- iq_chain.sv
`timescale 1ns/1ns

module iq_chain (
    input  logic            aclk,
    input  logic            arst_n,
    input  logic            advance,
    input  logic            accept,
    input  vna_pkg::iq_t    iq,
    output vna_pkg::polar_t polar,
    output logic            valid
);

    vna_pkg::iq_t filtered;

    // One FIR register plus the pre-rotation and the CORDIC iterations
    logic [vna_pkg::CORDIC_STAGES+1:0] valid_pipe;

    fir_15 fir_i_i (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .shift    (accept),
        .sample   (iq.i),
        .filtered (filtered.i)
    );

    fir_15 fir_q_i (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .shift    (accept),
        .sample   (iq.q),
        .filtered (filtered.q)
    );

    cordic_polar cordic_i (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .advance (advance),
        .iq      (filtered),
        .polar   (polar)
    );

    // Bubbles travel with the data so idle cycles never reach the averager
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            valid_pipe <= '0;
        end else if (advance) begin
            valid_pipe <= {valid_pipe[vna_pkg::CORDIC_STAGES:0], accept};
        end
    end

    assign valid = valid_pipe[vna_pkg::CORDIC_STAGES+1];

endmodule

//--- s_param_averager.sv
`timescale 1ns/1ns

module s_param_averager (
    input  logic               aclk,
    input  logic               arst_n,
    input  vna_pkg::avg_log2_t avg_log2,
    input  vna_pkg::polar_t    fwd1,
    input  vna_pkg::polar_t    rev1,
    input  vna_pkg::polar_t    fwd2,
    input  vna_pkg::polar_t    rev2,
    input  logic               sample_valid,
    input  logic               out_ready,
    output logic               advance,
    output logic               out_valid,
    output vna_pkg::s_matrix_t s_matrix
);

    vna_pkg::polar_t    wave_b [4];
    vna_pkg::polar_t    wave_a [4];
    vna_pkg::avg_acc_t  acc_mb [4];
    vna_pkg::avg_acc_t  acc_ma [4];
    vna_pkg::avg_acc_t  acc_ph [4];
    vna_pkg::avg_acc_t  sum_mb [4];
    vna_pkg::avg_acc_t  sum_ma [4];
    vna_pkg::avg_acc_t  sum_ph [4];
    vna_pkg::s_param_t  result [4];
    vna_pkg::avg_log2_t exp_q;
    vna_pkg::avg_log2_t exp_eff;
    logic [vna_pkg::AVG_LOG2_MAX-1:0] count;
    logic [vna_pkg::AVG_LOG2_MAX-1:0] count_last;
    logic take;
    logic last;

    // Whole pipeline holds while a matrix waits at the output
    assign advance = !(out_valid && !out_ready);
    assign take    = sample_valid && advance;

    // Index order S11, S12, S21, S22
    assign wave_b = '{rev1, rev1, rev2, rev2};
    assign wave_a = '{fwd1, fwd2, fwd1, fwd2};

    always_comb begin
        // New exponent is taken only on the first beat of a block
        if (count == '0) begin
            if (avg_log2 > vna_pkg::AVG_LOG2_MAX) begin
                exp_eff = vna_pkg::avg_log2_t'(vna_pkg::AVG_LOG2_MAX);
            end else begin
                exp_eff = avg_log2;
            end
        end else begin
            exp_eff = exp_q;
        end
        count_last = ~({vna_pkg::AVG_LOG2_MAX{1'b1}} << exp_eff);
        last       = (count == count_last);

        for (int p = 0; p < 4; p++) begin
            sum_mb[p] = acc_mb[p] + vna_pkg::avg_acc_t'(wave_b[p].mag);
            sum_ma[p] = acc_ma[p] + vna_pkg::avg_acc_t'(wave_a[p].mag);
            // wrapped difference, kept within half a turn
            sum_ph[p] = acc_ph[p]
                      + vna_pkg::avg_acc_t'($signed(wave_b[p].phase - wave_a[p].phase));
            result[p].mag_b = vna_pkg::mag_t'(sum_mb[p] >>> exp_eff);
            result[p].mag_a = vna_pkg::mag_t'(sum_ma[p] >>> exp_eff);
            result[p].phase = vna_pkg::phase_t'(sum_ph[p] >>> exp_eff);
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            count     <= '0;
            exp_q     <= '0;
            out_valid <= 1'b0;
            s_matrix  <= '0;
            for (int p = 0; p < 4; p++) begin
                acc_mb[p] <= '0;
                acc_ma[p] <= '0;
                acc_ph[p] <= '0;
            end
        end else begin
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            if (take) begin
                exp_q <= exp_eff;
                if (last) begin
                    count        <= '0;
                    out_valid    <= 1'b1;
                    s_matrix.s11 <= result[0];
                    s_matrix.s12 <= result[1];
                    s_matrix.s21 <= result[2];
                    s_matrix.s22 <= result[3];
                    for (int p = 0; p < 4; p++) begin
                        acc_mb[p] <= '0;
                        acc_ma[p] <= '0;
                        acc_ph[p] <= '0;
                    end
                end else begin
                    count <= count + 1'b1;
                    for (int p = 0; p < 4; p++) begin
                        acc_mb[p] <= sum_mb[p];
                        acc_ma[p] <= sum_ma[p];
                        acc_ph[p] <= sum_ph[p];
                    end
                end
            end
        end
    end

endmodule

//--- vna_dsp_top.sv
`timescale 1ns/1ns

module vna_dsp_top (
    input  logic               aclk,
    input  logic               arst_n,
    input  vna_pkg::avg_log2_t avg_log2,
    input  vna_pkg::adc_beat_t beat,
    input  logic               in_valid,
    output logic               in_ready,
    output vna_pkg::s_matrix_t s_matrix,
    output logic               out_valid,
    input  logic               out_ready
);

    vna_pkg::polar_t fwd1_polar;
    vna_pkg::polar_t rev1_polar;
    vna_pkg::polar_t fwd2_polar;
    vna_pkg::polar_t rev2_polar;
    logic advance;
    logic accept;
    logic sample_valid;

    assign accept   = in_valid && advance;
    assign in_ready = advance;

    // Chains run in lockstep, rev1 supplies the valid for all four
    iq_chain fwd1_chain_i (
        .aclk (aclk), .arst_n (arst_n), .advance (advance), .accept (accept),
        .iq (beat.fwd1), .polar (fwd1_polar), .valid ()
    );

    iq_chain rev1_chain_i (
        .aclk (aclk), .arst_n (arst_n), .advance (advance), .accept (accept),
        .iq (beat.rev1), .polar (rev1_polar), .valid (sample_valid)
    );

    iq_chain fwd2_chain_i (
        .aclk (aclk), .arst_n (arst_n), .advance (advance), .accept (accept),
        .iq (beat.fwd2), .polar (fwd2_polar), .valid ()
    );

    iq_chain rev2_chain_i (
        .aclk (aclk), .arst_n (arst_n), .advance (advance), .accept (accept),
        .iq (beat.rev2), .polar (rev2_polar), .valid ()
    );

    s_param_averager averager_i (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .avg_log2     (avg_log2),
        .fwd1         (fwd1_polar),
        .rev1         (rev1_polar),
        .fwd2         (fwd2_polar),
        .rev2         (rev2_polar),
        .sample_valid (sample_valid),
        .out_ready    (out_ready),
        .advance      (advance),
        .out_valid    (out_valid),
        .s_matrix     (s_matrix)
    );

endmodule

//--- vna_dsp_checker.sv
`timescale 1ns/1ns

module vna_dsp_checker (
    input logic               aclk,
    input logic               arst_n,
    input logic               in_ready,
    input logic               out_valid,
    input logic               out_ready,
    input vna_pkg::s_matrix_t s_matrix
);

    // A matrix waiting at the output must not move until it is taken
    hold_stable: assert property (@(posedge aclk) disable iff (!arst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(s_matrix)))
        else $error("out_valid or s_matrix changed while out_ready was low");

    // Only output back-pressure may stall the input
    ready_rule: assert property (@(posedge aclk) disable iff (!arst_n)
        !in_ready |-> (out_valid && !out_ready))
        else $error("in_ready low without a held matrix at the output");

    valid_known: assert property (@(posedge aclk) disable iff (!arst_n)
        !$isunknown(out_valid))
        else $error("out_valid is unknown");

endmodule

bind vna_dsp_top vna_dsp_checker checker_i (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .s_matrix  (s_matrix)
);

//--- tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic aclk,
    output logic arst_n
);

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    // Reset held for 8 cycles, released away from the active edge
    initial begin
        arst_n = 1'b0;
        repeat (8) @(posedge aclk);
        @(negedge aclk);
        arst_n = 1'b1;
    end

endmodule

//--- vna_dsp_tb.sv
`timescale 1ns/1ns

module vna_dsp_tb;

    localparam int BEATS_FULL  = 64;
    localparam int BEATS_AVG4  = 32;
    localparam int BEATS_AVG6  = 64;
    localparam int BEATS_GAPS  = 64;
    localparam int BEATS_BP    = 64;
    localparam int BEATS_MIXED = 64;
    localparam int TOTAL_BEATS = BEATS_FULL + BEATS_AVG4 + BEATS_AVG6 + BEATS_GAPS
                               + BEATS_BP + BEATS_MIXED;
    localparam int EXPECTED_BLOCKS = BEATS_FULL + BEATS_AVG4 / 16 + BEATS_AVG6 / 64
                                   + BEATS_GAPS + BEATS_BP + BEATS_MIXED / 16;
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_BEATS + 200;

    // Quiet period longer than the 15-cycle latency so a stray matrix shows up
    localparam int TAIL_CYCLES = 20;

    // Wave index order fwd1, rev1, fwd2, rev2; S order s11, s12, s21, s22
    localparam int B_WAVE [4] = '{1, 1, 3, 3};
    localparam int A_WAVE [4] = '{0, 2, 0, 2};

    logic               aclk;
    logic               arst_n;
    vna_pkg::avg_log2_t avg_log2;
    vna_pkg::adc_beat_t beat;
    logic               in_valid;
    logic               in_ready;
    vna_pkg::s_matrix_t s_matrix;
    logic               out_valid;
    logic               out_ready;

    logic [31:0]        rng_state;
    vna_pkg::sample_t   fir_hist [8][vna_pkg::FIR_TAPS-1];
    longint             sum_mb [4];
    longint             sum_ma [4];
    longint             sum_ph [4];
    int                 blk_count;
    int                 blk_exp;
    int                 outputs_seen;
    int                 cycle_count;
    logic               last_taken;
    logic               held;
    vna_pkg::s_matrix_t held_matrix;
    vna_pkg::s_matrix_t expected_q [$];

    tb_clock_gen clock_gen_i (
        .aclk   (aclk),
        .arst_n (arst_n)
    );

    vna_dsp_top dut_i (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .avg_log2  (avg_log2),
        .beat      (beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .s_matrix  (s_matrix),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %0t %s actual=%0h expected=%0h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_matrix(input vna_pkg::s_matrix_t act, input vna_pkg::s_matrix_t exp);
        vna_pkg::s_param_t act_p [4];
        vna_pkg::s_param_t exp_p [4];
        string             names [4];
        act_p = '{act.s11, act.s12, act.s21, act.s22};
        exp_p = '{exp.s11, exp.s12, exp.s21, exp.s22};
        names = '{"s11", "s12", "s21", "s22"};
        for (int p = 0; p < 4; p++) begin
            check_value($sformatf("s_matrix.%s.mag_b", names[p]), act_p[p].mag_b, exp_p[p].mag_b);
            check_value($sformatf("s_matrix.%s.mag_a", names[p]), act_p[p].mag_a, exp_p[p].mag_a);
            check_value($sformatf("s_matrix.%s.phase", names[p]), act_p[p].phase, exp_p[p].phase);
        end
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic chance(input int pct);
        return (next_random() % 100) < pct;
    endfunction

    function automatic vna_pkg::adc_beat_t random_beat();
        vna_pkg::adc_beat_t b;
        b.fwd1 = next_random();
        b.rev1 = next_random();
        b.fwd2 = next_random();
        b.rev2 = next_random();
        return b;
    endfunction

    // Direct-form FIR over accepted samples only with the sum scaled and clipped
    function automatic vna_pkg::sample_t fir_model(input int lane, input vna_pkg::sample_t sample);
        longint           acc;
        vna_pkg::sample_t res;
        acc = longint'(sample) * longint'(vna_pkg::FIR_COEFFS[0]);
        for (int j = 1; j < vna_pkg::FIR_TAPS; j++) begin
            acc = acc + longint'(fir_hist[lane][j-1]) * longint'(vna_pkg::FIR_COEFFS[j]);
        end
        for (int j = vna_pkg::FIR_TAPS - 2; j > 0; j--) begin
            fir_hist[lane][j] = fir_hist[lane][j-1];
        end
        fir_hist[lane][0] = sample;
        acc = acc >>> vna_pkg::FIR_SHIFT;
        if (acc > 32767) begin
            res = 16'sh7fff;
        end else if (acc < -32768) begin
            res = 16'sh8000;
        end else begin
            res = vna_pkg::sample_t'(acc);
        end
        return res;
    endfunction

    // Vectoring CORDIC that folds the left half plane over by half a turn first
    function automatic vna_pkg::polar_t cordic_model(input vna_pkg::sample_t i_in,
                                                     input vna_pkg::sample_t q_in);
        int              x;
        int              y;
        int              x_next;
        vna_pkg::phase_t z;
        vna_pkg::polar_t res;
        if (i_in < 0) begin
            x = -int'(i_in);
            y = -int'(q_in);
            z = 16'h8000;
        end else begin
            x = int'(i_in);
            y = int'(q_in);
            z = '0;
        end
        for (int k = 0; k < vna_pkg::CORDIC_STAGES; k++) begin
            if (y >= 0) begin
                x_next = x + (y >>> k);
                y      = y - (x >>> k);
                z      = z + vna_pkg::CORDIC_ATAN[k];
            end else begin
                x_next = x - (y >>> k);
                y      = y + (x >>> k);
                z      = z - vna_pkg::CORDIC_ATAN[k];
            end
            x = x_next;
        end
        res.mag   = vna_pkg::mag_t'(x >>> 2);
        res.phase = z;
        return res;
    endfunction

    task automatic clear_model();
        for (int l = 0; l < 8; l++) begin
            for (int j = 0; j < vna_pkg::FIR_TAPS - 1; j++) begin
                fir_hist[l][j] = '0;
            end
        end
        for (int p = 0; p < 4; p++) begin
            sum_mb[p] = 0;
            sum_ma[p] = 0;
            sum_ph[p] = 0;
        end
        blk_count = 0;
        blk_exp   = 0;
    endtask

    task automatic apply_beat(input vna_pkg::adc_beat_t bt);
        vna_pkg::sample_t   lane_in [8];
        vna_pkg::sample_t   lane_out [8];
        vna_pkg::polar_t    wave [4];
        vna_pkg::s_param_t  res [4];
        vna_pkg::s_matrix_t m;
        vna_pkg::phase_t    diff;
        lane_in = '{bt.fwd1.i, bt.fwd1.q, bt.rev1.i, bt.rev1.q,
                    bt.fwd2.i, bt.fwd2.q, bt.rev2.i, bt.rev2.q};
        for (int l = 0; l < 8; l++) begin
            lane_out[l] = fir_model(l, lane_in[l]);
        end
        for (int n = 0; n < 4; n++) begin
            wave[n] = cordic_model(lane_out[2*n], lane_out[2*n+1]);
        end
        if (blk_count == 0) begin
            blk_exp = (avg_log2 > vna_pkg::AVG_LOG2_MAX) ? vna_pkg::AVG_LOG2_MAX : int'(avg_log2);
        end
        for (int p = 0; p < 4; p++) begin
            sum_mb[p] += longint'(wave[B_WAVE[p]].mag);
            sum_ma[p] += longint'(wave[A_WAVE[p]].mag);
            diff = wave[B_WAVE[p]].phase - wave[A_WAVE[p]].phase;
            sum_ph[p] += longint'($signed(diff));
        end
        blk_count++;
        if (blk_count == (1 << blk_exp)) begin
            for (int p = 0; p < 4; p++) begin
                res[p].mag_b = vna_pkg::mag_t'(sum_mb[p] >>> blk_exp);
                res[p].mag_a = vna_pkg::mag_t'(sum_ma[p] >>> blk_exp);
                res[p].phase = vna_pkg::phase_t'(sum_ph[p] >>> blk_exp);
                sum_mb[p] = 0;
                sum_ma[p] = 0;
                sum_ph[p] = 0;
            end
            m.s11 = res[0];
            m.s12 = res[1];
            m.s21 = res[2];
            m.s22 = res[3];
            expected_q.push_back(m);
            blk_count = 0;
        end
    endtask

    task automatic take_output();
        vna_pkg::s_matrix_t exp_m;
        if (expected_q.size() == 0) begin
            $display("S-matrix delivered at %0t with no block pending in the model", $time);
            abort_run();
        end else begin
            exp_m = expected_q.pop_front();
            check_matrix(s_matrix, exp_m);
            outputs_seen++;
        end
    endtask

    // Inputs are set at the falling edge before this is called
    task automatic clock_cycle();
        #1;
        if (out_valid !== 1'b0 && out_valid !== 1'b1) begin
            $display("out_valid is unknown at %0t", $time);
            abort_run();
        end
        check_value("in_ready", in_ready, !(out_valid && !out_ready));
        if (held) begin
            check_value("out_valid", out_valid, 1'b1);
            check_matrix(s_matrix, held_matrix);
        end
        last_taken = in_valid && in_ready;
        if (last_taken) begin
            apply_beat(beat);
        end
        if (out_valid && out_ready) begin
            take_output();
        end
        held        = out_valid && !out_ready;
        held_matrix = s_matrix;
        @(negedge aclk);
    endtask

    task automatic run_phase(input int n_beats, input int log2, input int valid_pct,
                             input int ready_pct);
        int sent;
        sent       = 0;
        last_taken = 1'b1;
        avg_log2   = vna_pkg::avg_log2_t'(log2);
        while (sent < n_beats) begin
            // A stalled beat stays on the bus until it is taken
            if (last_taken || !in_valid) begin
                in_valid = chance(valid_pct);
                beat     = random_beat();
            end
            out_ready = chance(ready_pct);
            clock_cycle();
            if (last_taken) begin
                sent++;
            end
        end
        in_valid = 1'b0;
        while (expected_q.size() > 0) begin
            out_ready = chance(ready_pct);
            clock_cycle();
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge aclk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, %0d of %0d S-matrices received",
                 cycle_count, outputs_seen, EXPECTED_BLOCKS);
        abort_run();
    end

    initial begin
        avg_log2     = '0;
        beat         = '0;
        in_valid     = 1'b0;
        out_ready    = 1'b1;
        rng_state    = 32'd1;
        outputs_seen = 0;
        held         = 1'b0;
        held_matrix  = '0;
        last_taken   = 1'b0;
        clear_model();

        @(negedge aclk);
        #1;
        while (!arst_n) begin
            check_value("out_valid", out_valid, 1'b0);
            check_value("in_ready", in_ready, 1'b1);
            @(negedge aclk);
            #1;
        end
        @(negedge aclk);

        run_phase(BEATS_FULL, 0, 100, 100);
        run_phase(BEATS_AVG4, 4, 100, 100);
        run_phase(BEATS_AVG6, 6, 100, 100);
        run_phase(BEATS_GAPS, 0, 60, 100);
        run_phase(BEATS_BP, 0, 100, 60);
        run_phase(BEATS_MIXED, 4, 70, 50);

        // Any matrix beyond the expected ones is taken here and has nothing to match
        in_valid  = 1'b0;
        out_ready = 1'b1;
        repeat (TAIL_CYCLES) begin
            clock_cycle();
        end

        $display("Test OK");
        $finish;
    end

endmodule

//--- build.f
vna_pkg.sv
fir_15.sv
cordic_polar.sv
iq_chain.sv
s_param_averager.sv
vna_dsp_top.sv
vna_dsp_checker.sv
tb_clock_gen.sv
vna_dsp_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= vna_dsp_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
